//--- project.f
+incdir+include
hw/fpnc_pkg.sv
hw/fpnc_classifier.sv
hw/fpnc_pipe.sv
hw/fpnc_ops.sv
hw/fpnc_top.sv
tb/fpnc_tb.sv

//--- Makefile
# Verilator flow for the non-computational FPU

VERILATOR ?= verilator
FILELIST  ?= project.f
TB_TOP    ?= fpnc_tb
RTL_TOP   ?= fpnc_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= ALL TESTS PASSED
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- include/fpnc_ref_model.svh
// Expected response model
`ifndef FPNC_REF_MODEL_SVH
`define FPNC_REF_MODEL_SVH

// Ten-class mask of one operand, straight from the fields
function automatic fpnc_pkg::classmask_e operand_class(fpnc_pkg::fp_t x);
  logic exp_ones;
  logic exp_zero;
  logic man_zero;
  exp_ones = &x.exponent;
  exp_zero = ~|x.exponent;
  man_zero = ~|x.mantissa;
  if (exp_ones && !man_zero) begin
    return x.mantissa[fpnc_pkg::MAN_BITS-1] ? fpnc_pkg::QNAN : fpnc_pkg::SNAN;
  end
  if (exp_ones) return x.sign ? fpnc_pkg::NEGINF : fpnc_pkg::POSINF;
  if (exp_zero && man_zero) return x.sign ? fpnc_pkg::NEGZERO : fpnc_pkg::POSZERO;
  if (exp_zero) return x.sign ? fpnc_pkg::NEGSUBNORM : fpnc_pkg::POSSUBNORM;
  return x.sign ? fpnc_pkg::NEGNORM : fpnc_pkg::POSNORM;
endfunction

// ---------------------------------------------------------------------------
// Full response, ordering from the IEEE value of each operand
// ---------------------------------------------------------------------------
function automatic fpnc_pkg::fpnc_rsp_t expected_response(fpnc_pkg::fpnc_req_t req);
  fpnc_pkg::fpnc_rsp_t  rsp;
  fpnc_pkg::fp_t        a;
  fpnc_pkg::fp_t        b;
  fpnc_pkg::classmask_e cls_a;
  fpnc_pkg::classmask_e cls_b;
  logic                 any_snan;
  logic                 any_nan;
  logic                 both_zero;
  logic                 lt;
  logic                 eq;
  logic                 is_max;
  logic [30:0]          mag_a;
  logic [30:0]          mag_b;
  a        = req.operand_a;
  b        = req.operand_b;
  cls_a    = operand_class(a);
  cls_b    = operand_class(b);
  any_snan = (cls_a == fpnc_pkg::SNAN) || (cls_b == fpnc_pkg::SNAN);
  any_nan  = any_snan || (cls_a == fpnc_pkg::QNAN) || (cls_b == fpnc_pkg::QNAN);
  mag_a    = {a.exponent, a.mantissa};
  mag_b    = {b.exponent, b.mantissa};
  // Zeros of either sign are the same value
  both_zero = (cls_a inside {fpnc_pkg::NEGZERO, fpnc_pkg::POSZERO}) &&
              (cls_b inside {fpnc_pkg::NEGZERO, fpnc_pkg::POSZERO});
  eq        = both_zero || (a == b);
  // Among negatives the larger magnitude is the smaller value
  if (both_zero) begin
    lt = 1'b0;
  end else if (a.sign != b.sign) begin
    lt = a.sign;
  end else if (a.sign) begin
    lt = mag_a > mag_b;
  end else begin
    lt = mag_a < mag_b;
  end
  is_max   = (req.subop == fpnc_pkg::RTZ);
  rsp            = '0;
  rsp.tag        = req.tag;
  rsp.class_mask = cls_a;
  case (req.op)
    fpnc_pkg::SGNJ: begin
      rsp.result = a;
      if (req.subop == fpnc_pkg::RNE) rsp.result.sign = b.sign;
      if (req.subop == fpnc_pkg::RTZ) rsp.result.sign = ~b.sign;
      if (req.subop == fpnc_pkg::RDN) rsp.result.sign = a.sign ^ b.sign;
      rsp.extension_bit = req.op_mod ? rsp.result.sign : 1'b1;
    end
    fpnc_pkg::MINMAX: begin
      rsp.status.NV     = any_snan;
      rsp.extension_bit = 1'b1;
      if ((cls_a inside {fpnc_pkg::SNAN, fpnc_pkg::QNAN}) &&
          (cls_b inside {fpnc_pkg::SNAN, fpnc_pkg::QNAN})) begin
        rsp.result = fpnc_pkg::QNAN_CANON;
      end else if (cls_a inside {fpnc_pkg::SNAN, fpnc_pkg::QNAN}) begin
        rsp.result = b;
      end else if (cls_b inside {fpnc_pkg::SNAN, fpnc_pkg::QNAN}) begin
        rsp.result = a;
      end else begin
        // Zero tie: min takes the negative one
        rsp.result = ((eq ? a.sign : lt) ^ is_max) ? a : b;
      end
    end
    fpnc_pkg::CMP: begin
      if (any_snan) begin
        rsp.status.NV = 1'b1;
      end else if (req.subop == fpnc_pkg::RDN) begin
        rsp.result.mantissa[0] = any_nan ? req.op_mod : (eq ^ req.op_mod);
      end else if (req.subop inside {fpnc_pkg::RNE, fpnc_pkg::RTZ}) begin
        if (any_nan) begin
          rsp.status.NV = 1'b1;
        end else begin
          rsp.result.mantissa[0] = ((req.subop == fpnc_pkg::RNE) ? (lt | eq) : lt) ^ req.op_mod;
        end
      end
    end
    default: rsp.is_class = 1'b1;
  endcase
  return rsp;
endfunction

`endif

//--- tb/fpnc_tb.sv
// Non-computational FPU testbench

`timescale 1ns/1ps

module fpnc_tb import fpnc_pkg::*; ();

  `include "fpnc_ref_model.svh"

  localparam logic [31:0] SEED          = 32'h7c2b;
  localparam int          HS_TIMEOUT    = 100;
  localparam int          DRAIN_TIMEOUT = 400;

  // Corner pairs: ordered, swapped, signed zeros, NaN mixes, equal, subnormal
  localparam logic [31:0] PAIR_A [13] = '{
    32'h3f800000, 32'h40000000, 32'hbf800000, 32'h80000000, 32'h00000000,
    32'hc0000000, 32'h7fc00000, 32'h3f800000, 32'h7f800001, 32'h7fc00000,
    32'h7f800001, 32'h40a00000, 32'h00000001
  };
  localparam logic [31:0] PAIR_B [13] = '{
    32'h40000000, 32'h3f800000, 32'h3f800000, 32'h00000000, 32'h80000000,
    32'hc0400000, 32'h3f800000, 32'h7fa00000, 32'h7fc00000, 32'h7fd00000,
    32'hff800000, 32'h40a00000, 32'h80000003
  };
  // One operand per class, bit 0 of the mask upward
  localparam logic [31:0] CLASS_OPS [10] = '{
    32'hff800000, 32'hbf800000, 32'h80000001, 32'h80000000, 32'h00000000,
    32'h00000001, 32'h3f800000, 32'h7f800000, 32'h7f800001, 32'h7fc00000
  };

  logic      clk_i;
  logic      arst_n_i;
  logic      flush_i;
  fpnc_req_t req_i;
  logic      in_valid_i;
  logic      in_ready_o;
  fpnc_rsp_t rsp_o;
  logic      out_valid_o;
  logic      out_ready_i;
  logic      busy_o;

  // Consumer ready is either a fixed level or the random stream
  logic        ready_level;
  logic        bp_mode;
  logic        bp_ready;
  logic        lat_check;
  logic [31:0] stim_state;
  logic [31:0] ready_state;
  tag_t        tag_cnt;

  // Scoreboard state
  fpnc_rsp_t exp_q [$];
  fpnc_rsp_t exp_front;
  int        exp_count;
  int        errors;
  int        err_base;
  int        tests_run;
  int        tests_ok;
  int        rsp_count;
  logic      in_xfer;
  logic      out_xfer;

  assign out_ready_i = bp_mode ? bp_ready : ready_level;
  assign in_xfer     = in_valid_i && in_ready_o;
  assign out_xfer    = out_valid_o && out_ready_i;

  fpnc_top UUT (
    .clk_i       ( clk_i       ),
    .arst_n_i    ( arst_n_i    ),
    .flush_i     ( flush_i     ),
    .req_i       ( req_i       ),
    .in_valid_i  ( in_valid_i  ),
    .in_ready_o  ( in_ready_o  ),
    .rsp_o       ( rsp_o       ),
    .out_valid_o ( out_valid_o ),
    .out_ready_i ( out_ready_i ),
    .busy_o      ( busy_o      )
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // ------------------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------------------
  function automatic logic [31:0] next_rand(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // Biased toward zero and all-ones exponents to hit subnormals, inf and NaN
  task automatic random_operand(output logic [31:0] x);
    stim_state = next_rand(stim_state);
    x = stim_state;
    if (stim_state[1:0] == 2'd0) x[30:23] = 8'h00;
    if (stim_state[1:0] == 2'd1) x[30:23] = 8'hff;
  endtask

  task automatic finish_run();
    $display("summary: %0d tests, %0d clean, %0d responses, %0d errors",
             tests_run, tests_ok, rsp_count, errors);
    if (errors == 0 && exp_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  endtask

  task automatic start_test();
    err_base = errors;
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (errors == err_base) tests_ok++;
    $display("test %-14s %0d error(s)", name, errors - err_base);
  endtask

  // Drive on the falling edge, hold until the DUT takes it
  task automatic send_request(input op_e op, input subop_e subop, input logic mod,
                              input logic [31:0] a, input logic [31:0] b);
    int waited;
    @(negedge clk_i);
    req_i.operand_a = fp_t'(a);
    req_i.operand_b = fp_t'(b);
    req_i.op        = op;
    req_i.subop     = subop;
    req_i.op_mod    = mod;
    req_i.tag       = tag_cnt;
    tag_cnt         = tag_cnt + tag_t'(1);
    in_valid_i      = 1'b1;
    waited          = 0;
    @(posedge clk_i);
    while (!in_ready_o && waited < HS_TIMEOUT) begin
      waited++;
      @(posedge clk_i);
    end
    if (!in_ready_o) begin
      $display("timeout: request was never accepted by the DUT");
      errors++;
    end
  endtask

  // Idle the input and wait until every expected response has left
  task automatic drain_pipeline();
    int waited;
    @(negedge clk_i);
    in_valid_i = 1'b0;
    waited     = 0;
    while ((exp_count != 0 || busy_o) && waited < DRAIN_TIMEOUT) begin
      waited++;
      @(negedge clk_i);
    end
    if (exp_count != 0 || busy_o) begin
      $display("timeout: pipeline did not drain, %0d responses missing", exp_count);
      errors++;
    end
  endtask

  // Random consumer ready, about three cycles in four
  always @(negedge clk_i) begin : ready_stream
    ready_state = next_rand(ready_state);
    bp_ready   <= ready_state[3] | ready_state[7];
  end

  // ------------------------------------------------------------------------
  // Scoreboard queue
  // ------------------------------------------------------------------------
  always @(posedge clk_i or negedge arst_n_i) begin : scoreboard
    if (!arst_n_i) begin
      exp_q.delete();
      exp_front <= '0;
      exp_count <= 0;
    end else begin
      if (flush_i) begin
        exp_q.delete();
      end else begin
        if (out_xfer && exp_q.size() != 0) begin
          void'(exp_q.pop_front());
          rsp_count++;
        end
        if (in_xfer) exp_q.push_back(expected_response(req_i));
      end
      exp_front <= (exp_q.size() != 0) ? exp_q[0] : '0;
      exp_count <= exp_q.size();
    end
  end

  // Field by field against the oldest expected response
  a_result: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    out_xfer |-> rsp_o.result == exp_front.result)
    else begin
      $display("FAILED rsp_o.result got %h expected %h",
               $sampled(rsp_o.result), $sampled(exp_front.result));
      errors++;
    end
  a_status: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    out_xfer |-> rsp_o.status == exp_front.status)
    else begin
      $display("FAILED rsp_o.status got %h expected %h",
               $sampled(rsp_o.status), $sampled(exp_front.status));
      errors++;
    end
  a_ext: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    out_xfer |-> rsp_o.extension_bit == exp_front.extension_bit)
    else begin
      $display("FAILED rsp_o.extension_bit got %h expected %h",
               $sampled(rsp_o.extension_bit), $sampled(exp_front.extension_bit));
      errors++;
    end
  a_mask: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    out_xfer |-> rsp_o.class_mask == exp_front.class_mask)
    else begin
      $display("FAILED rsp_o.class_mask got %h expected %h",
               $sampled(rsp_o.class_mask), $sampled(exp_front.class_mask));
      errors++;
    end
  a_is_class: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    out_xfer |-> rsp_o.is_class == exp_front.is_class)
    else begin
      $display("FAILED rsp_o.is_class got %h expected %h",
               $sampled(rsp_o.is_class), $sampled(exp_front.is_class));
      errors++;
    end
  // Tag order shows loss, duplication or reordering
  a_tag: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    out_xfer |-> rsp_o.tag == exp_front.tag)
    else begin
      $display("FAILED rsp_o.tag got %h expected %h",
               $sampled(rsp_o.tag), $sampled(exp_front.tag));
      errors++;
    end
  a_extra: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    out_xfer |-> exp_count != 0)
    else begin
      $display("response came out although none was expected");
      errors++;
    end
  // Two register stages with the consumer always ready
  a_latency: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    lat_check |-> out_valid_o == $past(in_xfer, 2))
    else begin
      $display("out_valid_o did not follow the accepted request by two cycles");
      errors++;
    end
  a_busy: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    exp_count != 0 |-> busy_o)
    else begin
      $display("busy_o was low while responses were still in flight");
      errors++;
    end
  a_flush: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    flush_i && !in_valid_i |=> !busy_o)
    else begin
      $display("busy_o stayed high after a flush");
      errors++;
    end

  // ------------------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------------------
  initial begin : main
    logic [31:0] sel;
    logic [31:0] a;
    logic [31:0] b;
    arst_n_i    = 1'b0;
    flush_i     = 1'b0;
    req_i       = '0;
    in_valid_i  = 1'b0;
    ready_level = 1'b1;
    bp_mode     = 1'b0;
    lat_check   = 1'b0;
    tag_cnt     = '0;
    errors      = 0;
    err_base    = 0;
    tests_run   = 0;
    tests_ok    = 0;
    rsp_count   = 0;
    stim_state  = SEED;
    ready_state = next_rand(SEED);
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;
    @(negedge clk_i);
    assert (!out_valid_o && !busy_o && in_ready_o)
      else begin
        $display("outputs were not idle after reset");
        errors++;
      end

    start_test();
    for (int s = 0; s < 4; s++) begin
      for (int m = 0; m < 2; m++) begin
        for (int i = 0; i < 13; i++) begin
          send_request(SGNJ, subop_e'(3'(s)), 1'(m), PAIR_A[i], PAIR_B[i]);
        end
      end
    end
    drain_pipeline();
    report_test("sign_injection");

    start_test();
    for (int s = 0; s < 2; s++) begin
      for (int i = 0; i < 13; i++) begin
        send_request(MINMAX, subop_e'(3'(s)), 1'b0, PAIR_A[i], PAIR_B[i]);
      end
    end
    drain_pipeline();
    report_test("min_max");

    // LE, LT, EQ with and without inversion
    start_test();
    for (int s = 0; s < 3; s++) begin
      for (int m = 0; m < 2; m++) begin
        for (int i = 0; i < 13; i++) begin
          send_request(CMP, subop_e'(3'(s)), 1'(m), PAIR_A[i], PAIR_B[i]);
        end
      end
    end
    drain_pipeline();
    report_test("compare");

    start_test();
    for (int i = 0; i < 10; i++) begin
      send_request(CLASSIFY, RNE, 1'b0, CLASS_OPS[i], 32'h0);
    end
    drain_pipeline();
    report_test("classify");

    // Back-to-back burst then isolated requests
    start_test();
    lat_check = 1'b1;
    for (int i = 0; i < 6; i++) begin
      send_request(op_e'(2'(i)), RNE, 1'b0, PAIR_A[i], PAIR_B[i]);
    end
    drain_pipeline();
    send_request(CMP, RDN, 1'b0, PAIR_A[11], PAIR_B[11]);
    drain_pipeline();
    lat_check = 1'b0;
    report_test("latency");

    start_test();
    bp_mode = 1'b1;
    for (int i = 0; i < 48; i++) begin
      stim_state = next_rand(stim_state);
      sel        = stim_state;
      random_operand(a);
      random_operand(b);
      // Equal and sign-flipped pairs now and then
      if (sel[8]) b = a;
      if (sel[9]) b[31] = ~b[31];
      send_request(op_e'(sel[1:0]), subop_e'({1'b0, sel[3:2]}), sel[4], a, b);
    end
    drain_pipeline();
    bp_mode = 1'b0;
    report_test("back_pressure");

    // Fill both stages while stalled, then drop them
    start_test();
    ready_level = 1'b0;
    send_request(SGNJ, RNE, 1'b0, PAIR_A[0], PAIR_B[0]);
    send_request(MINMAX, RTZ, 1'b0, PAIR_A[1], PAIR_B[1]);
    @(negedge clk_i);
    in_valid_i = 1'b0;
    flush_i    = 1'b1;
    @(negedge clk_i);
    flush_i     = 1'b0;
    ready_level = 1'b1;
    repeat (4) @(negedge clk_i);
    send_request(CLASSIFY, RNE, 1'b0, CLASS_OPS[6], 32'h0);
    drain_pipeline();
    report_test("flush");

    finish_run();
  end

endmodule

//--- hw/fpnc_top.sv
// Pipelined non-computational FPU

`timescale 1ns/1ps

module fpnc_top import fpnc_pkg::*; #(
  parameter int unsigned NumInpRegs = 1,
  parameter int unsigned NumOutRegs = 1
) (
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      flush_i,
  // Request handshake
  input  fpnc_req_t req_i,
  input  logic      in_valid_i,
  output logic      in_ready_o,
  // Response handshake
  output fpnc_rsp_t rsp_o,
  output logic      out_valid_o,
  input  logic      out_ready_i,
  // Items in flight
  output logic      busy_o
);

  localparam int unsigned ReqWidth = $bits(fpnc_req_t);
  localparam int unsigned RspWidth = $bits(fpnc_rsp_t);

  logic [ReqWidth-1:0] inp_data;
  logic [RspWidth-1:0] out_data;
  fpnc_req_t           ops_req;
  fpnc_rsp_t           ops_rsp;
  logic                mid_valid;
  logic                mid_ready;
  logic                inp_busy;
  logic                out_busy;

  // Request delay ahead of the operation logic
  fpnc_pipe #(
    .DataWidth ( ReqWidth   ),
    .NumRegs   ( NumInpRegs )
  ) u_inp_pipe (
    .clk_i    ( clk_i            ),
    .arst_n_i ( arst_n_i         ),
    .flush_i  ( flush_i          ),
    .data_i   ( ReqWidth'(req_i) ),
    .valid_i  ( in_valid_i       ),
    .ready_o  ( in_ready_o       ),
    .data_o   ( inp_data         ),
    .valid_o  ( mid_valid        ),
    .ready_i  ( mid_ready        ),
    .busy_o   ( inp_busy         )
  );

  assign ops_req = fpnc_req_t'(inp_data);

  // Purely combinational between the two pipes
  fpnc_ops u_ops (
    .req_i ( ops_req ),
    .rsp_o ( ops_rsp )
  );

  // Response delay, valid and ready meet the input pipe directly
  fpnc_pipe #(
    .DataWidth ( RspWidth   ),
    .NumRegs   ( NumOutRegs )
  ) u_out_pipe (
    .clk_i    ( clk_i              ),
    .arst_n_i ( arst_n_i           ),
    .flush_i  ( flush_i            ),
    .data_i   ( RspWidth'(ops_rsp) ),
    .valid_i  ( mid_valid          ),
    .ready_o  ( mid_ready          ),
    .data_o   ( out_data           ),
    .valid_o  ( out_valid_o        ),
    .ready_i  ( out_ready_i        ),
    .busy_o   ( out_busy           )
  );

  assign rsp_o  = fpnc_rsp_t'(out_data);
  assign busy_o = inp_busy | out_busy;

endmodule

//--- hw/fpnc_ops.sv
// Non-computational operation datapath

`timescale 1ns/1ps

module fpnc_ops import fpnc_pkg::*; (
  input  fpnc_req_t req_i,
  output fpnc_rsp_t rsp_o
);

  fp_t      operand_a;
  fp_t      operand_b;
  fp_info_t info_a;
  fp_info_t info_b;

  assign operand_a = req_i.operand_a;
  assign operand_b = req_i.operand_b;

  fpnc_classifier u_classifier (
    .operand_a_i ( operand_a ),
    .operand_b_i ( operand_b ),
    .info_a_o    ( info_a    ),
    .info_b_o    ( info_b    )
  );

  // ------------------------------------------------------------------------
  // Shared relations
  // ------------------------------------------------------------------------
  logic any_nan;
  logic sig_nan;
  logic operands_equal;
  logic a_smaller;

  assign any_nan = info_a.is_nan | info_b.is_nan;
  assign sig_nan = info_a.is_signalling | info_b.is_signalling;
  // +0 and -0 compare equal
  assign operands_equal = (operand_a == operand_b) || (info_a.is_zero && info_b.is_zero);
  // Sign-magnitude order: unsigned compare flips when a sign is set
  assign a_smaller = (operand_a < operand_b) ^ (operand_a.sign || operand_b.sign);

  // ------------------------------------------------------------------------
  // Sign injection
  // ------------------------------------------------------------------------
  fp_t sgnj_result;

  always_comb begin : sign_injection
    sgnj_result = operand_a;
    unique case (req_i.subop)
      RNE:     sgnj_result.sign = operand_b.sign;
      RTZ:     sgnj_result.sign = ~operand_b.sign;
      RDN:     sgnj_result.sign = operand_a.sign ^ operand_b.sign;
      default: sgnj_result      = operand_a;  // RUP, plain move
    endcase
  end

  // ------------------------------------------------------------------------
  // Min and max, quiet NaN handling
  // ------------------------------------------------------------------------
  fp_t  minmax_result;
  logic is_max;

  assign is_max = (req_i.subop == RTZ);

  always_comb begin : min_max
    if (info_a.is_nan && info_b.is_nan) begin
      minmax_result = QNAN_CANON;
    end else if (info_a.is_nan) begin
      minmax_result = operand_b;
    end else if (info_b.is_nan) begin
      minmax_result = operand_a;
    end else begin
      minmax_result = (a_smaller ^ is_max) ? operand_a : operand_b;
    end
  end

  // ------------------------------------------------------------------------
  // Comparisons
  // ------------------------------------------------------------------------
  logic    cmp_bool;
  status_t cmp_status;
  fp_t     cmp_result;

  always_comb begin : comparisons
    cmp_bool   = 1'b0;
    cmp_status = '0;
    // sNaN is always invalid and false
    if (sig_nan) begin
      cmp_status.NV = 1'b1;
    end else begin
      unique case (req_i.subop)
        RNE, RTZ: begin
          // Signalling compares, any NaN is invalid
          if (any_nan) begin
            cmp_status.NV = 1'b1;
          end else if (req_i.subop == RNE) begin
            cmp_bool = (a_smaller | operands_equal) ^ req_i.op_mod;
          end else begin
            cmp_bool = (a_smaller & ~operands_equal) ^ req_i.op_mod;
          end
        end
        RDN: cmp_bool = any_nan ? req_i.op_mod : (operands_equal ^ req_i.op_mod);
        default: cmp_bool = 1'b0;
      endcase
    end
  end

  // Boolean lands in bit 0
  assign cmp_result = '{sign: 1'b0, exponent: '0, mantissa: man_t'(cmp_bool)};

  // ------------------------------------------------------------------------
  // Classification of operand A
  // ------------------------------------------------------------------------
  classmask_e class_mask;

  always_comb begin : classify
    if (info_a.is_normal) begin
      class_mask = operand_a.sign ? NEGNORM : POSNORM;
    end else if (info_a.is_subnormal) begin
      class_mask = operand_a.sign ? NEGSUBNORM : POSSUBNORM;
    end else if (info_a.is_zero) begin
      class_mask = operand_a.sign ? NEGZERO : POSZERO;
    end else if (info_a.is_inf) begin
      class_mask = operand_a.sign ? NEGINF : POSINF;
    end else begin
      class_mask = info_a.is_signalling ? SNAN : QNAN;
    end
    assert ($onehot(class_mask)) else $error("class mask not one-hot: %b", class_mask);
  end

  // ------------------------------------------------------------------------
  // Result selection
  // ------------------------------------------------------------------------
  always_comb begin : select_result
    rsp_o            = '0;
    rsp_o.class_mask = class_mask;
    rsp_o.is_class   = (req_i.op == CLASSIFY);
    rsp_o.tag        = req_i.tag;
    unique case (req_i.op)
      SGNJ: begin
        rsp_o.result        = sgnj_result;
        // Integer sign-extension when op_mod asks for it
        rsp_o.extension_bit = req_i.op_mod ? sgnj_result.sign : 1'b1;
      end
      MINMAX: begin
        rsp_o.result        = minmax_result;
        rsp_o.status.NV     = sig_nan;
        rsp_o.extension_bit = 1'b1;
      end
      CMP: begin
        rsp_o.result        = cmp_result;
        rsp_o.status        = cmp_status;
        rsp_o.extension_bit = 1'b0;
      end
      CLASSIFY: begin
        rsp_o.result        = '0;
        rsp_o.extension_bit = 1'b0;
      end
    endcase
  end

endmodule

//--- hw/fpnc_pipe.sv
// Elastic register pipeline

`timescale 1ns/1ps

module fpnc_pipe #(
  parameter int unsigned DataWidth = 32,
  parameter int unsigned NumRegs   = 1
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 flush_i,
  // Upstream side
  input  logic [DataWidth-1:0] data_i,
  input  logic                 valid_i,
  output logic                 ready_o,
  // Downstream side
  output logic [DataWidth-1:0] data_o,
  output logic                 valid_o,
  input  logic                 ready_i,
  // Any stage holds an item
  output logic                 busy_o
);

  // Index i is the signal after i register stages
  logic [DataWidth-1:0] data_q  [NumRegs+1];
  logic                 valid_q [NumRegs+1];
  // Ready is combinational through every stage
  logic                 ready   [NumRegs+1];

  // Stage 0 is the upstream input itself
  assign data_q[0]  = data_i;
  assign valid_q[0] = valid_i;
  assign ready_o    = ready[0];

  // ------------------------------------------------------------------------
  // Register stages
  // ------------------------------------------------------------------------
  for (genvar i = 0; i < NumRegs; i++) begin : gen_stage
    logic reg_ena;

    // Advance when the next stage drains or only holds a bubble
    assign ready[i] = ready[i+1] | ~valid_q[i+1];

    // Valid bit, flush wins over the handshake
    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        valid_q[i+1] <= 1'b0;
      end else if (flush_i) begin
        valid_q[i+1] <= 1'b0;
      end else if (ready[i]) begin
        valid_q[i+1] <= valid_q[i];
      end
    end

    // Payload only moves with a real item
    assign reg_ena = ready[i] & valid_q[i];

    always_ff @(posedge clk_i) begin
      if (reg_ena) begin
        data_q[i+1] <= data_q[i];
      end
    end
  end

  // Last stage faces the downstream consumer
  assign ready[NumRegs] = ready_i;
  assign data_o         = data_q[NumRegs];
  assign valid_o        = valid_q[NumRegs];

  // OR of the registered stage valids
  always_comb begin : busy_reduce
    busy_o = 1'b0;
    for (int i = 1; i <= NumRegs; i++) begin
      busy_o = busy_o | valid_q[i];
    end
  end

  // A stalled output item must not change under the consumer
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    valid_o && !ready_i && !flush_i |=> $stable(data_o))
    else $error("pipe output changed while stalled");

endmodule

//--- hw/fpnc_classifier.sv
// Operand class decoder

`timescale 1ns/1ps

module fpnc_classifier import fpnc_pkg::*; (
  input  fp_t      operand_a_i,
  input  fp_t      operand_b_i,
  output fp_info_t info_a_o,
  output fp_info_t info_b_o
);

  // Decode one operand from its exponent and mantissa fields
  function automatic fp_info_t classify(fp_t op);
    fp_info_t info;
    logic     exp_ones;
    logic     exp_zero;
    logic     man_zero;
    exp_ones = &op.exponent;
    exp_zero = ~|op.exponent;
    man_zero = ~|op.mantissa;
    info.is_normal    = !exp_ones && !exp_zero;
    info.is_subnormal = exp_zero && !man_zero;
    info.is_zero      = exp_zero && man_zero;
    info.is_inf       = exp_ones && man_zero;
    info.is_nan       = exp_ones && !man_zero;
    // Quiet bit is the top of the mantissa
    info.is_signalling = info.is_nan && !op.mantissa[MAN_BITS-1];
    info.is_quiet      = info.is_nan && op.mantissa[MAN_BITS-1];
    return info;
  endfunction

  // Five main categories as a vector for the checks
  function automatic logic [4:0] main_class(fp_info_t info);
    return {info.is_normal, info.is_subnormal, info.is_zero, info.is_inf, info.is_nan};
  endfunction

  // ------------------------------------------------------------------------
  // Both operands share the same decoder
  // ------------------------------------------------------------------------
  always_comb begin : decode
    info_a_o = classify(operand_a_i);
    info_b_o = classify(operand_b_i);
    // Every encoding falls in exactly one category
    assert ($onehot(main_class(info_a_o)))
      else $error("operand A class not unique: %b", main_class(info_a_o));
    assert ($onehot(main_class(info_b_o)))
      else $error("operand B class not unique: %b", main_class(info_b_o));
  end

endmodule

//--- hw/fpnc_pkg.sv
// Binary32 non-computational FPU types

package fpnc_pkg;

  // ------------------------------------------------------------------------
  // Format constants
  // ------------------------------------------------------------------------
  localparam int unsigned FP_WIDTH  = 32;
  localparam int unsigned EXP_BITS  = 8;
  localparam int unsigned MAN_BITS  = 23;
  localparam int unsigned TAG_WIDTH = 4;

  typedef logic [EXP_BITS-1:0]  exp_t;
  typedef logic [MAN_BITS-1:0]  man_t;
  typedef logic [TAG_WIDTH-1:0] tag_t;

  // IEEE 754 field layout, sign on top
  typedef struct packed {
    logic sign;
    exp_t exponent;
    man_t mantissa;
  } fp_t;

  // Per-operand class information
  typedef struct packed {
    logic is_normal;
    logic is_subnormal;
    logic is_zero;
    logic is_inf;
    logic is_nan;
    logic is_signalling;
    logic is_quiet;
  } fp_info_t;

  // Exception flags in RISC-V fflags order
  typedef struct packed {
    logic NV;
    logic DZ;
    logic OF;
    logic UF;
    logic NX;
  } status_t;

  // ------------------------------------------------------------------------
  // Operation encodings
  // ------------------------------------------------------------------------
  typedef enum logic [1:0] {
    SGNJ,
    MINMAX,
    CMP,
    CLASSIFY
  } op_e;

  // Sub-operation rides in the rounding-mode field
  typedef enum logic [2:0] {
    RNE = 3'b000,
    RTZ = 3'b001,
    RDN = 3'b010,
    RUP = 3'b011
  } subop_e;

  // One-hot class codes, bit 0 upward
  typedef enum logic [9:0] {
    NEGINF     = 10'b00_0000_0001,
    NEGNORM    = 10'b00_0000_0010,
    NEGSUBNORM = 10'b00_0000_0100,
    NEGZERO    = 10'b00_0000_1000,
    POSZERO    = 10'b00_0001_0000,
    POSSUBNORM = 10'b00_0010_0000,
    POSNORM    = 10'b00_0100_0000,
    POSINF     = 10'b00_1000_0000,
    SNAN       = 10'b01_0000_0000,
    QNAN       = 10'b10_0000_0000
  } classmask_e;

  // ------------------------------------------------------------------------
  // Request and response payloads
  // ------------------------------------------------------------------------
  typedef struct packed {
    fp_t    operand_a;
    fp_t    operand_b;
    subop_e subop;
    op_e    op;
    logic   op_mod;
    tag_t   tag;
  } fpnc_req_t;

  typedef struct packed {
    fp_t        result;
    status_t    status;
    logic       extension_bit;
    classmask_e class_mask;
    logic       is_class;
    tag_t       tag;
  } fpnc_rsp_t;

  // Positive, all-ones exponent, only the quiet bit set
  localparam fp_t QNAN_CANON = '{
    sign:     1'b0,
    exponent: '1,
    mantissa: man_t'(1) << (MAN_BITS - 1)
  };

endpackage
